// File: hdl/lane_stream_pkg.sv
`default_nettype none

package lane_stream_pkg;

    // Width of one signed element in bits.
    localparam int elem_w = 8;

    // Right shift applied to negative lanes under the leaky operation.
    localparam int leaky_shift = 3;

    // Operation applied by the activation stage to every lane of a word.
    typedef enum logic [1:0] {
        act_pass  = 2'd0,
        act_relu  = 2'd1,
        act_leaky = 2'd2
    } act_op_e;

    // Counter width needed to index n positions.
    // A single position still gets one bit so the counter is never zero wide.
    function automatic int idx_w(input int n);
        if (n > 1) begin
            return $clog2(n);
        end
        return 1;
    endfunction

endpackage

`default_nettype wire

// File: hdl/lane_packer.sv
`default_nettype none

module lane_packer #(
    parameter int in_lanes  = 2,
    parameter int mid_lanes = 4
) (
    input  wire logic                                         clk,
    input  wire logic                                         rst,
    input  wire logic [in_lanes*lane_stream_pkg::elem_w-1:0]  in_data,
    input  wire logic                                         in_valid,
    output logic                                              in_ready,
    output logic [mid_lanes*lane_stream_pkg::elem_w-1:0]      packed_data,
    output logic                                              packed_valid,
    input  wire logic                                         packed_ready
);

    // Number of input beats that make up one wide word.
    localparam int beats = mid_lanes / in_lanes;
    localparam int grp_w = in_lanes * lane_stream_pkg::elem_w;
    localparam int cnt_w = lane_stream_pkg::idx_w(beats);

    logic [cnt_w-1:0]                               beat_cnt;
    logic [mid_lanes*lane_stream_pkg::elem_w-1:0]   word;
    logic                                           accept;
    logic                                           last_beat;

    // A held word blocks new beats until it leaves.
    // When it leaves in this cycle the first beat of the next word may enter.
    assign in_ready    = !packed_valid || packed_ready;
    assign accept      = in_valid && in_ready;
    assign last_beat   = (beat_cnt == cnt_w'(beats - 1));
    assign packed_data = word;

    // Each accepted beat lands in the lane group chosen by the beat counter.
    always_ff @(posedge clk) begin
        for (int g = 0; g < beats; g++) begin
            if (accept && (beat_cnt == cnt_w'(g))) begin
                word[g*grp_w +: grp_w] <= in_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt     <= '0;
            packed_valid <= 1'b0;
        end else begin
            if (packed_valid && packed_ready) begin
                packed_valid <= 1'b0;
            end
            if (accept) begin
                if (last_beat) begin
                    beat_cnt     <= '0;
                    packed_valid <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/lane_activation.sv
`default_nettype none

module lane_activation #(
    parameter int lanes = 4
) (
    input  wire logic                                     clk,
    input  wire logic                                     rst,
    input  wire lane_stream_pkg::act_op_e                 op,
    input  wire logic [lanes*lane_stream_pkg::elem_w-1:0] packed_data,
    input  wire logic                                     packed_valid,
    output logic                                          packed_ready,
    output logic [lanes*lane_stream_pkg::elem_w-1:0]      act_data,
    output logic                                          act_valid,
    input  wire logic                                     act_ready
);

    localparam int w = lane_stream_pkg::elem_w;

    logic [lanes*w-1:0] result;

    // Applies the selected operation to one signed lane.
    function automatic logic [w-1:0] apply_op(input lane_stream_pkg::act_op_e sel,
                                              input logic signed [w-1:0] x);
        logic signed [w-1:0] y;
        y = x;
        case (sel)
            lane_stream_pkg::act_relu:  if (x < 0) y = '0;
            lane_stream_pkg::act_leaky: if (x < 0) y = x >>> lane_stream_pkg::leaky_shift;
            default:                    y = x;
        endcase
        return y;
    endfunction

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            result[i*w +: w] = apply_op(op, packed_data[i*w +: w]);
        end
    end

    // The stage accepts a word whenever its register is empty or is being drained.
    assign packed_ready = !act_valid || act_ready;

    always_ff @(posedge clk) begin
        if (packed_valid && packed_ready) begin
            act_data <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            act_valid <= 1'b0;
        end else if (packed_ready) begin
            act_valid <= packed_valid;
        end
    end

endmodule

`default_nettype wire

// File: hdl/lane_unpacker.sv
`default_nettype none

module lane_unpacker #(
    parameter int mid_lanes = 4,
    parameter int out_lanes = 1
) (
    input  wire logic                                         clk,
    input  wire logic                                         rst,
    input  wire logic [mid_lanes*lane_stream_pkg::elem_w-1:0] act_data,
    input  wire logic                                         act_valid,
    output logic                                              act_ready,
    output logic [out_lanes*lane_stream_pkg::elem_w-1:0]      out_data,
    output logic                                              out_valid,
    input  wire logic                                         out_ready
);

    // Number of output beats needed to drain one wide word.
    localparam int slices  = mid_lanes / out_lanes;
    localparam int slice_w = out_lanes * lane_stream_pkg::elem_w;
    localparam int cnt_w   = lane_stream_pkg::idx_w(slices);

    logic [mid_lanes*lane_stream_pkg::elem_w-1:0]   store;
    logic                                           store_valid;
    logic [cnt_w-1:0]                               slice_cnt;
    logic                                           last_slice;
    logic                                           out_fire;

    assign last_slice = (slice_cnt == cnt_w'(slices - 1));
    assign out_fire   = out_valid && out_ready;
    assign out_valid  = store_valid;

    // A new word may enter once the store is empty or its last slice is leaving.
    assign act_ready  = !store_valid || (last_slice && out_ready);

    // Slice selection reads only registered state.
    always_comb begin
        out_data = store[0 +: slice_w];
        for (int s = 1; s < slices; s++) begin
            if (slice_cnt == cnt_w'(s)) begin
                out_data = store[s*slice_w +: slice_w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (act_valid && act_ready) begin
            store <= act_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            store_valid <= 1'b0;
            slice_cnt   <= '0;
        end else begin
            if (out_fire) begin
                if (last_slice) begin
                    slice_cnt   <= '0;
                    store_valid <= 1'b0;
                end else begin
                    slice_cnt <= slice_cnt + 1'b1;
                end
            end
            // A word arriving together with the last slice reloads the store at once.
            if (act_valid && act_ready) begin
                store_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/lane_convert_top.sv
`default_nettype none

module lane_convert_top #(
    parameter int in_lanes  = 2,
    parameter int mid_lanes = 4,
    parameter int out_lanes = 1
) (
    input  wire logic                                         clk,
    input  wire logic                                         rst,
    input  wire lane_stream_pkg::act_op_e                     op,
    input  wire logic [in_lanes*lane_stream_pkg::elem_w-1:0]  in_data,
    input  wire logic                                         in_valid,
    output logic                                              in_ready,
    output logic [out_lanes*lane_stream_pkg::elem_w-1:0]      out_data,
    output logic                                              out_valid,
    input  wire logic                                         out_ready
);

    // Packed stream between the packer and the activation stage.
    logic [mid_lanes*lane_stream_pkg::elem_w-1:0] packed_data;
    logic                                         packed_valid;
    logic                                         packed_ready;

    // Activated stream between the activation stage and the unpacker.
    logic [mid_lanes*lane_stream_pkg::elem_w-1:0] act_data;
    logic                                         act_valid;
    logic                                         act_ready;

    lane_packer #(
        .in_lanes  (in_lanes),
        .mid_lanes (mid_lanes)
    ) u_packer (
        .clk          (clk),
        .rst          (rst),
        .in_data      (in_data),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .packed_data  (packed_data),
        .packed_valid (packed_valid),
        .packed_ready (packed_ready)
    );

    lane_activation #(
        .lanes (mid_lanes)
    ) u_act (
        .clk          (clk),
        .rst          (rst),
        .op           (op),
        .packed_data  (packed_data),
        .packed_valid (packed_valid),
        .packed_ready (packed_ready),
        .act_data     (act_data),
        .act_valid    (act_valid),
        .act_ready    (act_ready)
    );

    lane_unpacker #(
        .mid_lanes (mid_lanes),
        .out_lanes (out_lanes)
    ) u_unpack (
        .clk       (clk),
        .rst       (rst),
        .act_data  (act_data),
        .act_valid (act_valid),
        .act_ready (act_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// File: tests/lane_convert_sva.sv
`default_nettype none

module lane_convert_sva #(
    parameter int out_w = 8,
    parameter int mid_w = 32
) (
    input wire logic             clk,
    input wire logic             rst,
    input wire logic [out_w-1:0] out_data,
    input wire logic             out_valid,
    input wire logic             out_ready,
    input wire logic [mid_w-1:0] packed_data,
    input wire logic             packed_valid,
    input wire logic             packed_ready,
    input wire logic             act_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // An output beat that is stalled must hold until the consumer takes it.
    out_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("out_valid or out_data changed while stalled");

    // The packed word waits unchanged for the activation stage.
    packed_hold: assert property (@(posedge clk) disable iff (rst)
        (packed_valid && !packed_ready) |=> (packed_valid && $stable(packed_data)))
        else $error("packed_valid or packed_data changed while stalled");

    // Synchronous reset clears every stage.
    reset_clear: assert property (@(posedge clk)
        rst |=> (!out_valid && !packed_valid && !act_valid))
        else $error("a valid flag was high in the cycle after reset");

endmodule

`default_nettype wire

// File: tests/tb_lane_convert.sv
`default_nettype none

module tb_lane_convert;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int in_w  = 2 * lane_stream_pkg::elem_w;
    localparam int out_w = lane_stream_pkg::elem_w;

    // Three random tests of 32 two-beat words plus the single latency word.
    localparam int total_beats = 3 * 32 * 2 + 2;
    localparam int max_cycles  = 40 * total_beats + 200;

    // Cycles allowed for the words still in flight to come out at the end of a test.
    localparam int drain_limit = 500;

    logic                      clk;
    logic                      rst;
    lane_stream_pkg::act_op_e  op;
    logic [in_w-1:0]           in_data;
    logic                      in_valid;
    logic                      in_ready;
    logic [out_w-1:0]          out_data;
    logic                      out_valid;
    logic                      out_ready;

    logic [7:0]  expected[$];
    int          out_cycles[$];
    int          cycle;
    int          last_in_cycle;
    int          out_count;
    int          err_count;
    int          tests_passed;
    int          tests_failed;
    bit          ready_random;
    logic [31:0] stim_state;
    logic [31:0] rdy_state;

    lane_convert_top #(
        .in_lanes  (2),
        .mid_lanes (4),
        .out_lanes (1)
    ) u_dut (
        .clk       (clk),
        .rst       (rst),
        .op        (op),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    bind lane_convert_top lane_convert_sva #(
        .out_w (out_lanes * lane_stream_pkg::elem_w),
        .mid_w (mid_lanes * lane_stream_pkg::elem_w)
    ) u_sva (
        .clk          (clk),
        .rst          (rst),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .packed_data  (packed_data),
        .packed_valid (packed_valid),
        .packed_ready (packed_ready),
        .act_valid    (act_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] draw_stim();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    // Reference rule per element, with the leaky shift written as a floor division.
    function automatic logic [7:0] expected_lane(input lane_stream_pkg::act_op_e sel,
                                                 input logic [7:0] x);
        int v;
        int d;
        int r;
        v = int'($signed(x));
        d = 1 << lane_stream_pkg::leaky_shift;
        r = v;
        if (v < 0) begin
            if (sel == lane_stream_pkg::act_relu) begin
                r = 0;
            end else if (sel == lane_stream_pkg::act_leaky) begin
                r = -((-v + d - 1) / d);
            end
        end
        return r[7:0];
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
            err_count++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // The output ready line is redrawn every cycle when back-pressure is on.
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (ready_random) begin
                rdy_state = xorshift32(rdy_state);
                out_ready = rdy_state[7];
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // Edge monitor: feeds the model, checks outputs and guards the run length.
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!rst && in_valid && in_ready) begin
            last_in_cycle = cycle;
            for (int l = 0; l < 2; l++) begin
                expected.push_back(expected_lane(op, in_data[l*8 +: 8]));
            end
        end
        if (!rst && out_valid && out_ready) begin
            out_count++;
            out_cycles.push_back(cycle);
            if (expected.size() == 0) begin
                $display("Output element %0h arrived when none was expected", out_data);
                err_count++;
            end else begin
                check_value("output element", 32'(out_data), 32'(expected.pop_front()));
            end
        end
        if (cycle >= max_cycles) begin
            $display("The run timed out after %0d cycles without finishing", cycle);
            $display("test failed");
            $finish;
        end
    end

    task automatic send_beat(input logic [in_w-1:0] data);
        in_data  = data;
        in_valid = 1'b1;
        // The beat transfers on the first edge that sees in_ready high.
        @(posedge clk);
        while (!in_ready) begin
            @(posedge clk);
        end
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_word(input logic [in_w-1:0] b0, input logic [in_w-1:0] b1,
                             input bit gaps);
        logic [31:0] r;
        send_beat(b0);
        if (gaps) begin
            r = draw_stim();
            repeat (int'(r[1:0])) begin
                @(posedge clk);
                #1;
            end
        end
        send_beat(b1);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (expected.size() != 0 && waited < drain_limit) begin
            @(posedge clk);
            #1;
            waited++;
        end
        check_value("elements left after drain", 32'(expected.size()), 32'd0);
        repeat (2) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("Test %s: ok", name);
            tests_passed++;
        end else begin
            $display("Test %s: %0d errors", name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    initial begin
        int          errs;
        int          count_before;
        logic [31:0] r0;
        logic [31:0] r1;
        rst          = 1'b1;
        op           = lane_stream_pkg::act_pass;
        in_data      = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b1;
        ready_random = 1'b0;
        stim_state   = 32'd50607;
        rdy_state    = 32'd50607;
        cycle        = 0;
        out_count    = 0;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        errs = err_count;
        check_value("out_valid after reset", 32'(out_valid), 32'd0);
        check_value("in_ready after reset", 32'(in_ready), 32'd1);
        report_test("reset state", errs);

        // A counting pattern makes any reordering of lanes easy to spot.
        errs = err_count;
        op = lane_stream_pkg::act_pass;
        for (int k = 0; k < 32; k++) begin
            send_word({8'(4*k + 1), 8'(4*k)}, {8'(4*k + 3), 8'(4*k + 2)}, 1'b0);
        end
        wait_drain();
        report_test("pass-through ordering", errs);

        errs = err_count;
        count_before = out_count;
        op = lane_stream_pkg::act_relu;
        ready_random = 1'b1;
        for (int k = 0; k < 32; k++) begin
            r0 = draw_stim();
            r1 = draw_stim();
            send_word(r0[15:0], r1[15:0], 1'b0);
        end
        wait_drain();
        ready_random = 1'b0;
        check_value("relu output count", 32'(out_count - count_before), 32'd128);
        report_test("relu under back-pressure", errs);

        errs = err_count;
        op = lane_stream_pkg::act_leaky;
        for (int k = 0; k < 32; k++) begin
            r0 = draw_stim();
            r1 = draw_stim();
            send_word(r0[15:0], r1[15:0], 1'b1);
        end
        wait_drain();
        report_test("leaky with input gaps", errs);

        errs = err_count;
        op = lane_stream_pkg::act_pass;
        out_cycles.delete();
        send_word(16'h8211, 16'h7f33, 1'b0);
        wait_drain();
        check_value("latency output count", 32'(out_cycles.size()), 32'd4);
        for (int k = 0; k < out_cycles.size(); k++) begin
            check_value("latency of output beat", 32'(out_cycles[k] - last_in_cycle),
                        32'(3 + k));
        end
        report_test("latency", errs);

        $display("Summary: %0d tests ok, %0d tests with errors, %0d errors",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
hdl/lane_stream_pkg.sv
hdl/lane_packer.sv
hdl/lane_activation.sv
hdl/lane_unpacker.sv
hdl/lane_convert_top.sv
tests/lane_convert_sva.sv
tests/tb_lane_convert.sv

// File: run_sim.sh
#!/bin/sh
# Compiles the lane converter testbench with Verilator and runs it.
# Exits non-zero when the build or run fails or the log reports a failure.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_lane_convert \
    -o tb_lane_convert \
    -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_lane_convert > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
